/* exe_stage.f */
+incdir+include
source/exe_pkg.sv
source/exe_ctrl.sv
source/exe_alu.sv
source/store_lane.sv
source/mem_request.sv
source/exe_stage.sv
dv/exe_checker.sv
dv/tb_exe_stage.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_exe_stage
FILELIST  = exe_stage.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "Result: PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/tb_exe_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exe_cfg.svh"

module tb_exe_stage;

    import exe_pkg::*;

    localparam int NUM_TXN     = 2000;
    localparam int CLK_PERIOD  = 8;
    localparam int WATCHDOG_NS = NUM_TXN * CLK_PERIOD * 6;

    logic        clk;
    logic        reset;
    logic        flush;
    logic        in_valid;
    logic        in_allowin;
    logic        out_allowin;
    logic        out_valid;
    ds_to_es_t   in_bus;
    es_to_ms_t   out_bus;
    es_to_ms_t   expected_bus;
    int          errors;
    int          checked;
    int          pending;
    int          accepted;

    function automatic logic [31:0] pick_src1(ds_to_es_t d);
        if (d.src1_is_sa) return {27'b0, d.imm[10:6]};
        if (d.src1_is_pc) return d.pc;
        return d.rs_value;
    endfunction

    function automatic logic [31:0] pick_src2(ds_to_es_t d);
        if (d.src2_is_imm) return {{16{d.imm[15]}}, d.imm};
        if (d.src2_is_zimm) return {16'h0000, d.imm};
        if (d.src2_is_8) return 32'd8;
        return d.rt_value;
    endfunction

    function automatic logic [31:0] alu_model(ds_to_es_t d);
        logic [31:0] a;
        logic [31:0] b;
        a = pick_src1(d);
        b = pick_src2(d);
        if (d.alu_op.add) return a + b;
        if (d.alu_op.sub) return a - b;
        if (d.alu_op.slt) return {31'b0, $signed(a) < $signed(b)};
        if (d.alu_op.sltu) return {31'b0, a < b};
        if (d.alu_op.op_and) return a & b;
        if (d.alu_op.op_nor) return ~(a | b);
        if (d.alu_op.op_or) return a | b;
        if (d.alu_op.op_xor) return a ^ b;
        if (d.alu_op.sll) return b << a[4:0];
        if (d.alu_op.srl) return b >> a[4:0];
        if (d.alu_op.sra) return $signed(b) >>> a[4:0];
        if (d.alu_op.lui) return {d.imm, 16'h0000};
        return 32'h0;
    endfunction

    // 33-bit signed result whose top two bits disagree
    function automatic logic overflow_model(ds_to_es_t d);
        logic [31:0] s1;
        logic [31:0] s2;
        logic [32:0] a;
        logic [32:0] b;
        logic [32:0] w;
        s1 = pick_src1(d);
        s2 = pick_src2(d);
        a  = {s1[31], s1};
        b  = {s2[31], s2};
        if (d.alu_op.add) begin
            w = a + b;
            return w[32] != w[31];
        end
        if (d.alu_op.sub) begin
            w = a - b;
            return w[32] != w[31];
        end
        return 1'b0;
    endfunction

    function automatic void store_model(input ds_to_es_t d, input logic [1:0] a,
                                        output logic [31:0] wdata, output logic [3:0] wstrb);
        logic [1:0] li;
        logic [1:0] src;
        logic       on;
        wdata = '0;
        wstrb = '0;
        for (int i = 0; i < 4; i++) begin
            li  = 2'(i);
            on  = 1'b0;
            src = 2'd0;
            if (d.store_op.sb) begin
                on = (li == a);
            end else if (d.store_op.sh) begin
                on  = (li[1] == a[1]);
                src = li - a;
            end else if (d.store_op.sw) begin
                on  = 1'b1;
                src = li;
            end else if (d.store_op.swl) begin
                on  = (li <= a);
                src = li + 2'd3 - a;
            end else if (d.store_op.swr) begin
                on  = (li >= a);
                src = li - a;
            end
            wstrb[i] = on;
            wdata[i*8 +: 8] = on ? d.rt_value[src*8 +: 8] : 8'h00;
        end
    endfunction

    function automatic logic [1:0] size_model(ds_to_es_t d, logic [1:0] a);
        if (d.store_op.sw || d.load_op.lw) return 2'd2;
        if (d.store_op.sh || d.load_op.lh || d.load_op.lhu) return 2'd1;
        if (d.store_op.swl) return (a >= 2'd2) ? 2'd2 : a;
        if (d.store_op.swr) return (a <= 2'd1) ? 2'd2 : 2'd3 - a;
        return 2'd0;
    endfunction

    function automatic es_to_ms_t model_result(ds_to_es_t d);
        logic [31:0] r;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        ov;
        logic        ades;
        logic        adel;
        logic        ex;
        es_to_ms_t   e;
        r = alu_model(d);
        store_model(d, r[1:0], wdata, wstrb);
        ov   = d.of_check && overflow_model(d);
        ades = (d.store_op.sw && r[1:0] != 2'b00) || (d.store_op.sh && r[0]);
        adel = (d.load_op.lw && r[1:0] != 2'b00) || ((d.load_op.lh || d.load_op.lhu) && r[0]);
        ex   = d.ds_ex || ov || ades || adel;
        e         = '0;
        e.pc      = d.pc;
        e.result  = r;
        e.dest    = d.dest;
        e.gr_we   = d.gr_we && !ex;
        e.is_load = |d.load_op;
        e.load_op = d.load_op;
        e.ex      = ex;
        if (d.ds_ex) begin
            e.exccode  = d.ds_exccode;
            e.badvaddr = d.ds_badvaddr;
        end else if (ov) begin
            e.exccode = `EXE_EX_OV;
        end else if (ades) begin
            e.exccode  = `EXE_EX_ADES;
            e.badvaddr = r;
        end else if (adel) begin
            e.exccode  = `EXE_EX_ADEL;
            e.badvaddr = r;
        end
        e.wr    = (|d.store_op) && !ex;
        e.addr  = (r[31:30] == 2'b10) ? {3'b000, r[28:0]} : r;
        e.wdata = wdata;
        e.size  = size_model(d, r[1:0]);
        e.wstrb = ex ? 4'b0000 : wstrb;
        return e;
    endfunction

    task automatic random_word(output ds_to_es_t d);
        int unsigned kind;
        int unsigned pick;
        d = '0;
        d.pc       = $urandom;
        d.rs_value = $urandom;
        d.rt_value = $urandom;
        d.imm      = 16'($urandom);
        d.dest     = 5'($urandom);
        d.gr_we    = ($urandom_range(0, 3) != 0);
        kind = $urandom_range(0, 3);
        if (kind < 2) begin
            // memory access at rs plus signed offset
            d.alu_op.add  = 1'b1;
            d.src2_is_imm = 1'b1;
            if (kind == 0) begin
                d.store_op = 5'b1 << $urandom_range(0, 4);
                d.gr_we    = 1'b0;
            end else begin
                d.load_op = 5'b1 << $urandom_range(0, 4);
                d.gr_we   = 1'b1;
            end
        end else begin
            d.alu_op   = 12'b1 << $urandom_range(0, 11);
            d.of_check = ($urandom_range(0, 1) == 1);
            pick = $urandom_range(0, 3);
            d.src1_is_sa = (pick == 0);
            d.src1_is_pc = (pick == 1);
            pick = $urandom_range(0, 4);
            d.src2_is_imm  = (pick == 0) && !d.alu_op.lui;
            d.src2_is_zimm = (pick == 1) || d.alu_op.lui;
            d.src2_is_8    = (pick == 2) && !d.alu_op.lui;
        end
        d.ds_ex       = ($urandom_range(0, 19) == 0);
        d.ds_exccode  = 5'($urandom);
        d.ds_badvaddr = $urandom;
    endtask

    exe_stage exe_stage_inst (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .in_valid    (in_valid),
        .in_bus      (in_bus),
        .in_allowin  (in_allowin),
        .out_allowin (out_allowin),
        .out_valid   (out_valid),
        .out_bus     (out_bus)
    );

    assign expected_bus = model_result(in_bus);

    exe_checker checker_inst (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .in_valid    (in_valid),
        .in_allowin  (in_allowin),
        .out_allowin (out_allowin),
        .out_valid   (out_valid),
        .out_bus     (out_bus),
        .expected    (expected_bus),
        .errors      (errors),
        .checked     (checked),
        .pending     (pending)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'hf139));
        reset       = 1'b1;
        flush       = 1'b0;
        in_valid    = 1'b0;
        out_allowin = 1'b0;
        in_bus      = '0;
        accepted    = 0;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        while (accepted < NUM_TXN) begin
            random_word(in_bus);
            in_valid    = ($urandom_range(0, 9) < 7);
            out_allowin = ($urandom_range(0, 9) < 7);
            flush       = ($urandom_range(0, 99) < 2);
            @(posedge clk);
            if (in_valid && in_allowin && !flush) begin
                accepted++;
            end
            #1;
        end
        // let the last word drain
        in_valid    = 1'b0;
        flush       = 1'b0;
        out_allowin = 1'b1;
        @(negedge clk);
        while (pending != 0) @(negedge clk);
        repeat (2) @(negedge clk);
        $display("errors %0d, results checked %0d, words accepted %0d",
                 errors, checked, accepted);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dv/exe_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module exe_checker (
    input  logic               clk,
    input  logic               reset,
    input  logic               flush,
    input  logic               in_valid,
    input  logic               in_allowin,
    input  logic               out_allowin,
    input  logic               out_valid,
    input  exe_pkg::es_to_ms_t out_bus,
    // model result for the word now on in_bus
    input  exe_pkg::es_to_ms_t expected,
    output int                 errors,
    output int                 checked,
    output int                 pending
);

    import exe_pkg::*;

    es_to_ms_t exp_q[$];
    es_to_ms_t want;
    es_to_ms_t last_bus;
    logic      was_stalled;
    logic      allow_exp;

    always @(posedge clk) begin
        if (reset) begin
            exp_q.delete();
            errors      = 0;
            checked     = 0;
            was_stalled = 1'b0;
        end else begin
            allow_exp = (exp_q.size() == 0) || out_allowin;
            if (in_allowin !== allow_exp) begin
                errors++;
                $display("error: in_allowin at %0t expected %0b actual %0b",
                         $time, allow_exp, in_allowin);
            end
            // no byte strobes without a valid result
            if (!out_valid && out_bus.wstrb !== '0) begin
                errors++;
                $display("error: idle_wstrb at %0t expected %h actual %h",
                         $time, 4'h0, out_bus.wstrb);
            end
            if (flush) begin
                if (out_valid) begin
                    errors++;
                    $display("out_valid was high during a flush at %0t", $time);
                end
                // held item dropped, nothing accepted
                exp_q.delete();
            end else begin
                if (was_stalled && out_valid && out_bus !== last_bus) begin
                    errors++;
                    $display("error: hold_bus at %0t expected %h actual %h",
                             $time, last_bus, out_bus);
                end
                if (out_valid && exp_q.size() == 0) begin
                    errors++;
                    $display("out_valid was high at %0t with no result expected", $time);
                end else if (!out_valid && exp_q.size() != 0) begin
                    errors++;
                    $display("a held result was not presented at %0t", $time);
                end else if (out_valid && out_allowin) begin
                    want = exp_q.pop_front();
                    checked++;
                    if (out_bus !== want) begin
                        errors++;
                        $display("error: result_bus at %0t expected %h actual %h",
                                 $time, want, out_bus);
                    end
                end
                if (in_valid && in_allowin) begin
                    exp_q.push_back(expected);
                end
            end
            was_stalled = out_valid && !out_allowin && !flush;
            last_bus    = out_bus;
        end
        pending = exp_q.size();
    end

endmodule

`default_nettype wire

/* source/exe_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exe_cfg.svh"

module exe_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                flush,

    // decode side
    input  logic                in_valid,
    input  exe_pkg::ds_to_es_t  in_bus,
    output logic                in_allowin,

    // memory side
    input  logic                out_allowin,
    output logic                out_valid,
    output exe_pkg::es_to_ms_t  out_bus
);

    import exe_pkg::*;

    ds_to_es_t            held;
    logic                 stage_valid;
    logic [`EXE_XLEN-1:0] alu_result;
    logic                 overflow;
    lane_out_t            lanes [`EXE_NUM_LANES];

    exe_ctrl ctrl_inst (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .in_valid    (in_valid),
        .in_bus      (in_bus),
        .in_allowin  (in_allowin),
        .out_allowin (out_allowin),
        .out_valid   (stage_valid),
        .held        (held)
    );

    // the held item is being dropped this cycle
    assign out_valid = stage_valid & ~flush;

    exe_alu alu_inst (
        .op       (held),
        .result   (alu_result),
        .overflow (overflow)
    );

    for (genvar g = 0; g < `EXE_NUM_LANES; g++) begin : gen_lane
        store_lane #(
            .LANE (g)
        ) lane_inst (
            .rt_value (held.rt_value),
            .store_op (held.store_op),
            .offset   (alu_result[1:0]),
            .lane     (lanes[g])
        );
    end

    mem_request req_inst (
        .op         (held),
        .alu_result (alu_result),
        .overflow   (overflow),
        .lanes      (lanes),
        .valid      (out_valid),
        .result     (out_bus)
    );

endmodule

`default_nettype wire

/* source/mem_request.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exe_cfg.svh"

module mem_request (
    input  exe_pkg::ds_to_es_t   op,
    input  logic [`EXE_XLEN-1:0] alu_result,
    input  logic                 overflow,
    input  exe_pkg::lane_out_t   lanes [`EXE_NUM_LANES],
    input  logic                 valid,
    output exe_pkg::es_to_ms_t   result
);

    logic [`EXE_XLEN-1:0]      wdata;
    logic [`EXE_NUM_LANES-1:0] wstrb;
    logic [1:0]                offset;
    logic [1:0]                size;
    logic [`EXE_XLEN-1:0]      addr;
    logic                      is_store;
    logic                      is_load;
    logic                      ov;
    logic                      ades;
    logic                      adel;
    logic                      ex;

    always_comb begin
        for (int i = 0; i < `EXE_NUM_LANES; i++) begin
            wdata[i*8 +: 8] = lanes[i].data;
            wstrb[i]        = lanes[i].strb;
        end
    end

    assign offset   = alu_result[1:0];
    assign is_store = |op.store_op;
    assign is_load  = |op.load_op;

    // access size, unaligned stores shrink with the offset
    always_comb begin
        size = 2'd0;
        if (op.store_op.sw || op.load_op.lw) begin
            size = 2'd2;
        end else if (op.store_op.sh || op.load_op.lh || op.load_op.lhu) begin
            size = 2'd1;
        end else if (op.store_op.swl) begin
            size = offset[1] ? 2'd2 : {1'b0, offset[0]};
        end else if (op.store_op.swr) begin
            size = !offset[1] ? 2'd2 : {1'b0, !offset[0]};
        end
    end

    // kseg0/kseg1 are unmapped
    assign addr = (alu_result[`EXE_XLEN-1 -: 2] == 2'b10) ? (alu_result & `EXE_KSEG_MASK)
                                                          : alu_result;

    assign ov   = op.of_check & overflow;
    assign ades = (op.store_op.sw & (offset != 2'b00)) | (op.store_op.sh & offset[0]);
    assign adel = (op.load_op.lw & (offset != 2'b00))
                | ((op.load_op.lh | op.load_op.lhu) & offset[0]);
    assign ex   = op.ds_ex | ov | ades | adel;

    always_comb begin
        result         = '0;
        result.pc      = op.pc;
        result.result  = alu_result;
        result.dest    = op.dest;
        result.gr_we   = op.gr_we & ~ex;
        result.is_load = is_load;
        result.load_op = op.load_op;
        result.ex      = ex;
        // upstream exception wins over anything found here
        if (op.ds_ex) begin
            result.exccode  = op.ds_exccode;
            result.badvaddr = op.ds_badvaddr;
        end else if (ov) begin
            result.exccode  = `EXE_EX_OV;
        end else if (ades) begin
            result.exccode  = `EXE_EX_ADES;
            result.badvaddr = alu_result;
        end else if (adel) begin
            result.exccode  = `EXE_EX_ADEL;
            result.badvaddr = alu_result;
        end
        result.wr    = is_store & ~ex;
        result.addr  = addr;
        result.wdata = wdata;
        result.size  = size;
        result.wstrb = (valid && !ex) ? wstrb : '0;
    end

endmodule

`default_nettype wire

/* source/store_lane.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exe_cfg.svh"

module store_lane #(
    parameter int LANE = 0
) (
    input  logic [`EXE_XLEN-1:0] rt_value,
    input  exe_pkg::store_op_t   store_op,
    input  logic [1:0]           offset,
    output exe_pkg::lane_out_t   lane
);

    localparam logic [1:0] IDX = LANE[1:0];

    logic       strb;
    logic [1:0] sel;

    // which byte of rt lands here, and whether this lane is written
    always_comb begin
        strb = 1'b0;
        sel  = 2'd0;
        if (store_op.sb) begin
            strb = (IDX == offset);
            sel  = 2'd0;
        end else if (store_op.sh) begin
            strb = (IDX[1] == offset[1]);
            sel  = IDX - offset;
        end else if (store_op.sw) begin
            strb = 1'b1;
            sel  = IDX;
        end else if (store_op.swl) begin
            strb = (IDX <= offset);
            sel  = IDX + 2'd3 - offset;
        end else if (store_op.swr) begin
            strb = (IDX >= offset);
            sel  = IDX - offset;
        end
    end

    assign lane.strb = strb;
    assign lane.data = strb ? rt_value[sel*8 +: 8] : 8'h00;

endmodule

`default_nettype wire

/* source/exe_alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exe_cfg.svh"

module exe_alu (
    input  exe_pkg::ds_to_es_t   op,
    output logic [`EXE_XLEN-1:0] result,
    output logic                 overflow
);

    logic [`EXE_XLEN-1:0] src1;
    logic [`EXE_XLEN-1:0] src2;
    logic [`EXE_XLEN-1:0] adder_b;
    logic [`EXE_XLEN-1:0] sum;
    logic                 adder_cin;
    logic                 adder_cout;
    logic [4:0]           shamt;
    logic [`EXE_XLEN-1:0] slt_res;
    logic [`EXE_XLEN-1:0] sltu_res;
    logic [`EXE_XLEN-1:0] sll_res;
    logic [`EXE_XLEN-1:0] srl_res;
    logic [`EXE_XLEN-1:0] sra_res;
    logic [`EXE_XLEN-1:0] lui_res;

    // operand selection
    assign src1 = op.src1_is_sa ? {{(`EXE_XLEN-5){1'b0}}, op.imm[10:6]} :
                  op.src1_is_pc ? op.pc :
                                  op.rs_value;

    assign src2 = op.src2_is_imm  ? {{(`EXE_XLEN-16){op.imm[15]}}, op.imm} :
                  op.src2_is_zimm ? {{(`EXE_XLEN-16){1'b0}}, op.imm} :
                  op.src2_is_8    ? `EXE_XLEN'd8 :
                                    op.rt_value;

    // one adder serves add, sub and both compares
    assign adder_cin = op.alu_op.sub | op.alu_op.slt | op.alu_op.sltu;
    assign adder_b   = adder_cin ? ~src2 : src2;
    assign {adder_cout, sum} = {1'b0, src1} + {1'b0, adder_b} + {{`EXE_XLEN{1'b0}}, adder_cin};

    assign slt_res  = {{(`EXE_XLEN-1){1'b0}},
                       (src1[`EXE_XLEN-1] & ~src2[`EXE_XLEN-1]) |
                       (~(src1[`EXE_XLEN-1] ^ src2[`EXE_XLEN-1]) & sum[`EXE_XLEN-1])};
    // borrow out means src1 < src2 unsigned
    assign sltu_res = {{(`EXE_XLEN-1){1'b0}}, ~adder_cout};

    // shifts move src2 by the low five bits of src1
    assign shamt   = src1[4:0];
    assign sll_res = src2 << shamt;
    assign srl_res = src2 >> shamt;
    assign sra_res = $signed(src2) >>> shamt;
    assign lui_res = {src2[15:0], 16'b0};

    assign result = ({`EXE_XLEN{op.alu_op.add | op.alu_op.sub}} & sum)
                  | ({`EXE_XLEN{op.alu_op.slt}}    & slt_res)
                  | ({`EXE_XLEN{op.alu_op.sltu}}   & sltu_res)
                  | ({`EXE_XLEN{op.alu_op.op_and}} & (src1 & src2))
                  | ({`EXE_XLEN{op.alu_op.op_nor}} & ~(src1 | src2))
                  | ({`EXE_XLEN{op.alu_op.op_or}}  & (src1 | src2))
                  | ({`EXE_XLEN{op.alu_op.op_xor}} & (src1 ^ src2))
                  | ({`EXE_XLEN{op.alu_op.sll}}    & sll_res)
                  | ({`EXE_XLEN{op.alu_op.srl}}    & srl_res)
                  | ({`EXE_XLEN{op.alu_op.sra}}    & sra_res)
                  | ({`EXE_XLEN{op.alu_op.lui}}    & lui_res);

    // same-sign inputs giving an opposite-sign sum
    assign overflow = (op.alu_op.add | op.alu_op.sub)
                    & (src1[`EXE_XLEN-1] == adder_b[`EXE_XLEN-1])
                    & (sum[`EXE_XLEN-1] != src1[`EXE_XLEN-1]);

endmodule

`default_nettype wire

/* source/exe_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module exe_ctrl (
    input  logic                clk,
    input  logic                reset,
    input  logic                flush,

    // from decode
    input  logic                in_valid,
    input  exe_pkg::ds_to_es_t  in_bus,
    output logic                in_allowin,

    // toward memory
    input  logic                out_allowin,
    output logic                out_valid,
    output exe_pkg::ds_to_es_t  held
);

    logic accept;

    assign in_allowin = !out_valid || out_allowin;

    // a word arriving during flush is dropped as well
    assign accept = in_valid && in_allowin && !flush;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;
        end else if (in_allowin) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            held <= in_bus;
        end
    end

endmodule

`default_nettype wire

/* source/exe_pkg.sv */
`default_nettype none

`include "exe_cfg.svh"

package exe_pkg;

    // one-hot, add sits in bit 0
    typedef struct packed {
        logic lui;
        logic sra;
        logic srl;
        logic sll;
        logic op_xor;
        logic op_or;
        logic op_nor;
        logic op_and;
        logic sltu;
        logic slt;
        logic sub;
        logic add;
    } alu_op_t;

    // one-hot, sb sits in bit 0
    typedef struct packed {
        logic swr;
        logic swl;
        logic sw;
        logic sh;
        logic sb;
    } store_op_t;

    // one-hot, lb sits in bit 0
    typedef struct packed {
        logic lw;
        logic lhu;
        logic lh;
        logic lbu;
        logic lb;
    } load_op_t;

    typedef struct packed {
        logic [`EXE_XLEN-1:0]  pc;
        logic [`EXE_XLEN-1:0]  rs_value;
        logic [`EXE_XLEN-1:0]  rt_value;
        logic [15:0]           imm;
        logic [`EXE_REG_W-1:0] dest;
        logic                  src1_is_sa;
        logic                  src1_is_pc;
        logic                  src2_is_imm;
        logic                  src2_is_zimm;
        logic                  src2_is_8;
        logic                  gr_we;
        logic                  of_check;
        alu_op_t               alu_op;
        store_op_t             store_op;
        load_op_t              load_op;
        // exception raised before execute
        logic                  ds_ex;
        logic [`EXE_EXC_W-1:0] ds_exccode;
        logic [`EXE_XLEN-1:0]  ds_badvaddr;
    } ds_to_es_t;

    typedef struct packed {
        logic [7:0] data;
        logic       strb;
    } lane_out_t;

    typedef struct packed {
        logic [`EXE_XLEN-1:0]      pc;
        logic [`EXE_XLEN-1:0]      result;
        logic [`EXE_REG_W-1:0]     dest;
        logic                      gr_we;
        logic                      is_load;
        load_op_t                  load_op;
        logic                      ex;
        logic [`EXE_EXC_W-1:0]     exccode;
        logic [`EXE_XLEN-1:0]      badvaddr;
        // data memory request
        logic                      wr;
        logic [`EXE_XLEN-1:0]      addr;
        logic [`EXE_XLEN-1:0]      wdata;
        logic [1:0]                size;
        logic [`EXE_NUM_LANES-1:0] wstrb;
    } es_to_ms_t;

endpackage

`default_nettype wire

/* include/exe_cfg.svh */
`ifndef EXE_CFG_SVH
`define EXE_CFG_SVH

// datapath widths
`define EXE_XLEN        32
`define EXE_REG_W       5
`define EXE_EXC_W       5

// one-hot operation widths, must match the package structs
`define EXE_ALU_OP_W    12
`define EXE_STORE_OP_W  5
`define EXE_LOAD_OP_W   5

// bytes per data word
`define EXE_NUM_LANES   4

// exception codes
`define EXE_EX_ADEL     5'd4
`define EXE_EX_ADES     5'd5
`define EXE_EX_OV       5'd12

// unmapped kseg0/kseg1 window drops the top three address bits
`define EXE_KSEG_MASK   32'h1fff_ffff

`endif
